//--- dv/ldpc_ibuf_tb.sv
/*
  ldpc input buffer testbench
  directed tests of the ping-pong banks, width conversion and
  frame tags against a small reference model kept in the bench
*/
`timescale 1ns/100ps
`default_nettype none

module ldpc_ibuf_tb import ldpc_ibuf_pkg::*; ();

  localparam int DEPTH    = 2 ** ADDR_W;                      // words per bank
  localparam int FILL_CYC = DEPTH * LANES;                    // one lane per cycle
  localparam int RUN_CYC  = 6 * 12 + 4 * FILL_CYC + 5 * DEPTH + 300;
  localparam int WDOG_CYC = 2 * RUN_CYC;                      // twice the test length

  logic     iwclk;
  logic     rst_n;
  lane_we_t lane_we;
  addr_t    waddr;
  wdat_t    wdat;
  logic     wfull;
  tag_t     wtag;
  logic     rempty;
  addr_t    raddr;
  rdat_t    rdat;
  tag_t     rtag;
  logic     empty_any;
  logic     empty_all;
  logic     full_any;
  logic     full_all;

  // reference model
  rdat_t       shadow [NBANK][DEPTH];   // packed lanes per bank and word
  tag_t        mtag [NBANK];
  int          mcnt;                    // filled banks
  int          mwptr;
  int          mrptr;
  logic [31:0] lfsr;
  int          nchecks;
  int          nerrors;

  ldpc_ibuf_top ldpc_ibuf_top_i (
    .iwclk (iwclk), .rst_n (rst_n), .lane_we (lane_we), .waddr (waddr), .wdat (wdat),
    .wfull (wfull), .wtag (wtag), .rempty (rempty), .raddr (raddr), .rdat (rdat),
    .rtag (rtag), .empty_any (empty_any), .empty_all (empty_all),
    .full_any (full_any), .full_all (full_all)
  );

  initial begin
    iwclk = 1'b0;
    forever #20 iwclk = ~iwclk;   // 40 ns period
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);   // galois step per bit
    end
    return v;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    nchecks++;
    if (got !== exp) begin
      nerrors++;
      $display("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // flags and rtag against the model
  task automatic check_flags(input string where);
    check_val(empty_any, mcnt != NBANK, {where, ": empty_any"});
    check_val(empty_all, mcnt == 0, {where, ": empty_all"});
    check_val(full_any, mcnt != 0, {where, ": full_any"});
    check_val(full_all, mcnt == NBANK, {where, ": full_all"});
    check_val(rtag, mtag[mrptr], {where, ": rtag"});
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(negedge iwclk);
    rst_n = 1'b1;
    mcnt  = 0;    // tag slots and ram keep their contents
    mwptr = 0;
    mrptr = 0;
    @(negedge iwclk);
  endtask

  task automatic write_word(input lane_we_t mask, input addr_t a, input wdat_t d);
    lane_we = mask;
    waddr   = a;
    wdat    = d;
    for (int g = 0; g < LANES; g++) begin
      if (mask[g]) shadow[mwptr][a][g*WDAT_W +: WDAT_W] = d;   // same byte each lane
    end
    @(negedge iwclk);
    lane_we = '0;
  endtask

  // random bytes into the write bank, one lane at a time
  task automatic fill_bank(input int nwords);
    logic [31:0] r;
    for (int a = 0; a < nwords; a++) begin
      for (int g = 0; g < LANES; g++) begin
        r = next_bits(WDAT_W);
        write_word(lane_we_t'(1 << g), addr_t'(a), r[WDAT_W-1:0]);
      end
    end
  endtask

  // one cycle pulse on wfull and/or rempty, model follows the acceptance rules
  task automatic pulse_strobes(input logic w, input logic r, input tag_t t);
    logic wacc;
    logic racc;
    wacc   = w && (mcnt != NBANK);
    racc   = r && (mcnt != 0);
    wfull  = w;
    rempty = r;
    wtag   = t;
    @(negedge iwclk);
    wfull  = 1'b0;
    rempty = 1'b0;
    if (wacc) begin
      mtag[mwptr] = t;
      mwptr       = (mwptr + 1) % NBANK;
    end
    if (racc) mrptr = (mrptr + 1) % NBANK;
    mcnt = mcnt + int'(wacc) - int'(racc);
  endtask

  task automatic close_random(output tag_t t);
    logic [31:0] r;
    r = next_bits(TAG_W);
    t = r[TAG_W-1:0];
    pulse_strobes(1'b1, 1'b0, t);
  endtask

  // pipelined read, a new address every cycle, data one cycle later
  task automatic read_bank(input int nwords);
    for (int i = 0; i <= nwords; i++) begin
      if (i > 0) begin
        check_val(rdat, shadow[mrptr][i-1],
                  $sformatf("rdat bank %0d word %0d", mrptr, i - 1));
      end
      if (i < nwords) begin
        raddr = addr_t'(i);
        @(negedge iwclk);
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic test_reset();
    apply_reset();
    check_flags("reset");
    check_val(rtag, 0, "rtag after reset");
  endtask

  task automatic test_fill_read();
    tag_t t;
    apply_reset();
    fill_bank(DEPTH);
    close_random(t);
    check_flags("fill_read closed");
    read_bank(DEPTH);
    pulse_strobes(1'b0, 1'b1, '0);
    check_flags("fill_read released");
  endtask

  task automatic test_ping_pong();
    tag_t t;
    apply_reset();
    fill_bank(DEPTH);
    close_random(t);
    fill_bank(DEPTH);
    close_random(t);
    check_flags("ping_pong both full");
    read_bank(DEPTH);                      // bank 0
    pulse_strobes(1'b0, 1'b1, '0);
    check_flags("ping_pong bank 0 out");   // rtag now bank 1, full_all low
    read_bank(DEPTH);                      // bank 1
    fill_bank(DEPTH);                      // refill bank 0
    close_random(t);
    pulse_strobes(1'b0, 1'b1, '0);
    check_flags("ping_pong refilled");
    read_bank(DEPTH);
    pulse_strobes(1'b0, 1'b1, '0);
  endtask

  task automatic test_refused_strobes();
    tag_t t;
    tag_t t0;
    apply_reset();
    fill_bank(16);
    close_random(t0);                      // bank 0 tag, shown on rtag
    fill_bank(16);
    close_random(t);
    pulse_strobes(1'b1, 1'b0, ~t0);        // refused, every bank full
    check_flags("refused wfull");
    check_val(rtag, t0, "rtag after refused wfull");
    pulse_strobes(1'b0, 1'b1, '0);
    pulse_strobes(1'b0, 1'b1, '0);
    pulse_strobes(1'b0, 1'b1, '0);         // refused, nothing filled
    check_flags("refused rempty");
    fill_bank(16);
    close_random(t);
    read_bank(16);                         // wrong bank if rused had moved
    pulse_strobes(1'b0, 1'b1, '0);
  endtask

  task automatic test_simultaneous();
    tag_t        t;
    logic [31:0] r;
    apply_reset();
    fill_bank(16);
    close_random(t);
    fill_bank(16);                         // bank 1 while bank 0 waits
    r = next_bits(TAG_W);
    t = r[TAG_W-1:0];
    while (t == mtag[0] || t == mtag[1]) t = t + 1'b1;   // unlike both stored tags
    pulse_strobes(1'b1, 1'b1, t);
    check_flags("simultaneous");           // count still one, rtag of bank 1
    read_bank(16);
    pulse_strobes(1'b0, 1'b1, '0);
  endtask

  task automatic test_multi_lane_write();
    tag_t        t;
    logic [31:0] r;
    apply_reset();
    for (int a = 0; a < 4; a++) begin
      r = next_bits(WDAT_W);
      write_word('1, addr_t'(a), r[WDAT_W-1:0]);
    end
    close_random(t);
    read_bank(4);                          // byte repeated in every lane
    pulse_strobes(1'b0, 1'b1, '0);
  endtask

  // ------------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------------
  initial begin
    rst_n   = 1'b0;
    lane_we = '0;
    waddr   = '0;
    wdat    = '0;
    wfull   = 1'b0;
    wtag    = '0;
    rempty  = 1'b0;
    raddr   = '0;
    lfsr    = 32'h2495_6dbc;
    nchecks = 0;
    nerrors = 0;
    for (int b = 0; b < NBANK; b++) mtag[b] = '0;
    test_reset();
    test_fill_read();
    test_ping_pong();
    test_refused_strobes();
    test_simultaneous();
    test_multi_lane_write();
    $display("checks run: %0d, errors: %0d", nchecks, nerrors);
    if (nerrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge iwclk);
    $display("timeout: tests still running after %0d clock cycles", WDOG_CYC);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- ldpc_ibuf.f
verilog/ldpc_ibuf_pkg.sv
verilog/bank_status_if.sv
verilog/bank_ptr_logic.sv
verilog/lane_ram.sv
verilog/ldpc_ibuffer.sv
verilog/ldpc_ibuf_top.sv
dv/ldpc_ibuf_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the ldpc input buffer testbench with Verilator and run it
# the run passes only if the pass line shows up in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f ldpc_ibuf.f \
    --top-module ldpc_ibuf_tb -Mdir obj_dir \
  && sim_out="$(./obj_dir/Vldpc_ibuf_tb)" ; echo "$sim_out" \
  && echo "$sim_out" | grep -qxF "All tests passed!" \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }

//--- verilog/bank_ptr_logic.sv
/*
  ping-pong bank control
  write/read bank pointers, filled bank counter and the
  four status flags, all registered on iwclk
*/
`timescale 1ns/100ps
`default_nettype none

module bank_ptr_logic import ldpc_ibuf_pkg::*; (
  input  logic       iwclk,
  input  logic       rst_n,
  input  logic       wfull,    // close write bank, 1 cycle pulse
  input  logic       rempty,   // release read bank, 1 cycle pulse
  bank_status_if.ptr bs
);

  bcnt_t cnt;        // filled banks
  bcnt_t cnt_nxt;
  logic  wr_ok;      // accepted wfull
  logic  rd_ok;      // accepted rempty

  //--------------------------------------------------------------------------
  // strobe acceptance
  //--------------------------------------------------------------------------
  // refused pulses are simply dropped
  assign wr_ok = wfull  & ~bs.full_all;
  assign rd_ok = rempty & ~bs.empty_all;

  always_comb begin
    cnt_nxt = cnt;
    case ({wr_ok, rd_ok})
      2'b10:   cnt_nxt = cnt + 1'b1;
      2'b01:   cnt_nxt = cnt - 1'b1;
      default: cnt_nxt = cnt;   // idle, or both at once
    endcase
  end

  //--------------------------------------------------------------------------
  // pointers and counter
  //--------------------------------------------------------------------------
  always_ff @(posedge iwclk or negedge rst_n) begin
    if (!rst_n) begin
      bs.wused <= '0;
      bs.rused <= '0;
      cnt      <= '0;
    end else begin
      if (wr_ok) begin
        bs.wused <= bs.wused + 1'b1;   // wraps at NBANK
      end
      if (rd_ok) begin
        bs.rused <= bs.rused + 1'b1;
      end
      cnt <= cnt_nxt;
    end
  end

  //--------------------------------------------------------------------------
  // status flags
  //--------------------------------------------------------------------------
  // decoded from the next count so they line up with cnt
  always_ff @(posedge iwclk or negedge rst_n) begin
    if (!rst_n) begin
      bs.empty_any <= 1'b1;
      bs.empty_all <= 1'b1;
      bs.full_any  <= 1'b0;
      bs.full_all  <= 1'b0;
    end else begin
      bs.empty_any <= (cnt_nxt != bcnt_t'(NBANK));
      bs.empty_all <= (cnt_nxt == '0);
      bs.full_any  <= (cnt_nxt != '0);
      bs.full_all  <= (cnt_nxt == bcnt_t'(NBANK));
    end
  end

endmodule

`default_nettype wire

//--- verilog/bank_status_if.sv
/*
  bank status bundle
  bank pointers and fill flags from the bank logic to the
  buffer and to the top level outputs
*/
`timescale 1ns/100ps
`default_nettype none

interface bank_status_if import ldpc_ibuf_pkg::*; ();

  bank_t wused;       // bank being written
  bank_t rused;       // bank being read
  logic  empty_any;   // at least one bank free
  logic  empty_all;   // nothing filled
  logic  full_any;    // at least one bank filled
  logic  full_all;    // every bank filled

  // bank logic side, owns everything
  modport ptr  (output wused, rused, empty_any, empty_all, full_any, full_all);

  // storage side, only the pointers
  modport buff (input wused, rused);

  // status outputs
  modport stat (input empty_any, empty_all, full_any, full_all);

endinterface

`default_nettype wire

//--- verilog/lane_ram.sv
/*
  single byte lane storage
  simple dual port ram spanning all banks, synchronous write,
  registered read with one cycle latency
*/
`timescale 1ns/100ps
`default_nettype none

module lane_ram import ldpc_ibuf_pkg::*; (
  input  logic                     iwclk,
  input  logic                     we,
  input  logic [BNUM_W+ADDR_W-1:0] waddr,   // {bank, word}
  input  wdat_t                    wdat,
  input  logic [BNUM_W+ADDR_W-1:0] raddr,   // {bank, word}
  output wdat_t                    rdat
);

  // NBANK banks of 64 bytes
  wdat_t mem [NBANK * (2 ** ADDR_W)];

  //--------------------------------------------------------------------------
  // write port
  //--------------------------------------------------------------------------
  always_ff @(posedge iwclk) begin
    if (we) begin
      mem[waddr] <= wdat;
    end
  end

  //--------------------------------------------------------------------------
  // read port
  //--------------------------------------------------------------------------
  // address sampled on the edge, data out right after it
  // same address write in the same cycle gives the old byte
  always_ff @(posedge iwclk) begin
    rdat <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- verilog/ldpc_ibuf_pkg.sv
/*
  ldpc decoder input buffer, shared definitions
  widths, lane and bank counts, vector types used by the
  bank logic, the lane storage and the top level
*/
`default_nettype none

package ldpc_ibuf_pkg;

  //--------------------------------------------------------------------------
  // sizes
  //--------------------------------------------------------------------------
  localparam int ADDR_W = 6;                // word address inside one bank
  localparam int WDAT_W = 8;                // write lane width
  localparam int LANES  = 4;                // read/write width ratio
  localparam int RDAT_W = LANES * WDAT_W;   // wide read word
  localparam int BNUM_W = 1;                // bank index width
  localparam int NBANK  = 2 ** BNUM_W;      // ping-pong, 2 banks
  localparam int TAG_W  = 8;                // frame tag

  //--------------------------------------------------------------------------
  // vector types
  //--------------------------------------------------------------------------
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [WDAT_W-1:0]   wdat_t;
  typedef logic [RDAT_W-1:0]   rdat_t;
  typedef logic [BNUM_W-1:0]   bank_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [LANES-1:0]    lane_we_t;   // one strobe per lane
  typedef logic [BNUM_W:0]     bcnt_t;      // filled banks, 0 .. NBANK

endpackage

`default_nettype wire

//--- verilog/ldpc_ibuf_top.sv
/*
  ldpc decoder input buffer, top level
  ping-pong byte lane buffer with width conversion and per
  bank frame tags, plain ports on the single iwclk domain
*/
`timescale 1ns/100ps
`default_nettype none

module ldpc_ibuf_top import ldpc_ibuf_pkg::*; (
  input  logic     iwclk,
  input  logic     rst_n,
  // write side
  input  lane_we_t lane_we,
  input  addr_t    waddr,
  input  wdat_t    wdat,
  input  logic     wfull,
  input  tag_t     wtag,
  // read side
  input  logic     rempty,
  input  addr_t    raddr,
  output rdat_t    rdat,
  output tag_t     rtag,
  // status
  output logic     empty_any,
  output logic     empty_all,
  output logic     full_any,
  output logic     full_all
);

  bank_status_if bs_i ();

  //--------------------------------------------------------------------------
  // bank control
  //--------------------------------------------------------------------------
  bank_ptr_logic bank_ptr_logic_i (
    .iwclk  (iwclk),
    .rst_n  (rst_n),
    .wfull  (wfull),
    .rempty (rempty),
    .bs     (bs_i.ptr)
  );

  //--------------------------------------------------------------------------
  // storage
  //--------------------------------------------------------------------------
  ldpc_ibuffer ldpc_ibuffer_i (
    .iwclk    (iwclk),
    .lane_we  (lane_we),
    .waddr    (waddr),
    .wdat     (wdat),
    .wfull    (wfull),
    .full_all (full_all),   // status flag, gates the tag write
    .wtag     (wtag),
    .raddr    (raddr),
    .rdat     (rdat),
    .rtag     (rtag),
    .bs       (bs_i.buff)
  );

  // status flags out
  assign empty_any = bs_i.empty_any;
  assign empty_all = bs_i.empty_all;
  assign full_any  = bs_i.full_any;
  assign full_all  = bs_i.full_all;

endmodule

`default_nettype wire

//--- verilog/ldpc_ibuffer.sv
/*
  ldpc input buffer storage
  LANES byte lanes written one at a time and read as one wide
  word, plus one frame tag slot per bank
*/
`timescale 1ns/100ps
`default_nettype none

module ldpc_ibuffer import ldpc_ibuf_pkg::*; (
  input  logic        iwclk,
  input  lane_we_t    lane_we,    // per lane write strobe
  input  addr_t       waddr,
  input  wdat_t       wdat,
  input  logic        wfull,      // close bank, latch tag
  input  logic        full_all,   // from stat flags, gates the tag write
  input  tag_t        wtag,
  input  addr_t       raddr,
  output rdat_t       rdat,
  output tag_t        rtag,
  bank_status_if.buff bs
);

  logic [BNUM_W+ADDR_W-1:0] lane_waddr;
  logic [BNUM_W+ADDR_W-1:0] lane_raddr;
  wdat_t                    lane_rdat [LANES];
  logic                     tag_we;

  //--------------------------------------------------------------------------
  // lane addressing
  //--------------------------------------------------------------------------
  // bank pointer on top, word address below
  assign lane_waddr = {bs.wused, waddr};
  assign lane_raddr = {bs.rused, raddr};

  //--------------------------------------------------------------------------
  // lane array
  //--------------------------------------------------------------------------
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    lane_ram lane_ram_i (
      .iwclk (iwclk),
      .we    (lane_we[g]),
      .waddr (lane_waddr),
      .wdat  (wdat),          // same byte to every selected lane
      .raddr (lane_raddr),
      .rdat  (lane_rdat[g])
    );

    // lane 0 lands in the low byte
    assign rdat[g*WDAT_W +: WDAT_W] = lane_rdat[g];
  end

  //--------------------------------------------------------------------------
  // tag storage
  //--------------------------------------------------------------------------
  // same acceptance rule as the bank counter
  assign tag_we = wfull & ~full_all;

  // starts cleared, rtag reads zero out of reset
  tag_t tag_mem [NBANK] = '{default: '0};

  always_ff @(posedge iwclk) begin
    if (tag_we) begin
      tag_mem[bs.wused] <= wtag;   // slot of the bank being closed
    end
  end

  assign rtag = tag_mem[bs.rused];   // follows rused, no extra delay

endmodule

`default_nettype wire
